//--- project.f
+incdir+verif
hw/cpu_pkg.sv
hw/fwd_if.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/pipe_cpu.sv
verif/tb_pipe_cpu.sv

//--- verif/tb_programs.svh
localparam int NUM_PROGS = 4;
localparam int MAX_CODE  = 24;
localparam int MAX_MCHK  = 4;
// Expected values at or above this name a data address from the random fill
localparam int FROM_MEM  = 'h10000;

cpu_pkg::instr_t code_tab  [NUM_PROGS][MAX_CODE];
int              code_len  [NUM_PROGS];
int              run_count [NUM_PROGS];
int              reg_exp   [NUM_PROGS][8];
int              mem_addr  [NUM_PROGS][MAX_MCHK];
int              mem_exp   [NUM_PROGS][MAX_MCHK];
int              mem_n     [NUM_PROGS];
int              cur_prog;

function automatic cpu_pkg::instr_t rr_word(cpu_pkg::opcode_e op, int rd, int rs1, int rs2);
    return {op, rd[2:0], 1'b0, rs1[2:0], 1'b0, rs2[2:0]};
endfunction

function automatic cpu_pkg::instr_t ri_word(cpu_pkg::opcode_e op, int rd, int imm);
    return {op, rd[2:0], imm[7:0]};
endfunction

function automatic cpu_pkg::instr_t rm_word(cpu_pkg::opcode_e op, int rd, int rs1, int imm);
    return {op, rd[2:0], 1'b0, rs1[2:0], imm[3:0]};
endfunction

task automatic emit(input cpu_pkg::instr_t w);
    code_tab[cur_prog][code_len[cur_prog]] = w;
    code_len[cur_prog] = code_len[cur_prog] + 1;
endtask

task automatic mem_word_check(input int addr, input int e);
    mem_addr[cur_prog][mem_n[cur_prog]] = addr;
    mem_exp[cur_prog][mem_n[cur_prog]]  = e;
    mem_n[cur_prog] = mem_n[cur_prog] + 1;
endtask

task automatic end_program(input int runs, input int e0, e1, e2, e3, e4, e5, e6, e7);
    run_count[cur_prog]  = runs;
    reg_exp[cur_prog][0] = e0;
    reg_exp[cur_prog][1] = e1;
    reg_exp[cur_prog][2] = e2;
    reg_exp[cur_prog][3] = e3;
    reg_exp[cur_prog][4] = e4;
    reg_exp[cur_prog][5] = e5;
    reg_exp[cur_prog][6] = e6;
    reg_exp[cur_prog][7] = e7;
    cycle_limit = cycle_limit + 4 * code_len[cur_prog] + 20;
    cur_prog    = cur_prog + 1;
endtask

task automatic build_programs();
    cur_prog    = 0;
    cycle_limit = 0;

    // ALU chain with producers one to three slots ahead
    emit(ri_word(cpu_pkg::OP_LDIH, 1, 'h12));
    emit(ri_word(cpu_pkg::OP_ADDI, 1, 'h34));
    emit(ri_word(cpu_pkg::OP_ADDI, 2, 'h0F));
    emit(rr_word(cpu_pkg::OP_ADD, 3, 1, 2));
    emit(ri_word(cpu_pkg::OP_LDIH, 4, 'hA5));
    emit(ri_word(cpu_pkg::OP_ADDI, 4, 'h5A));
    emit(rr_word(cpu_pkg::OP_SUB, 5, 4, 3));
    emit(ri_word(cpu_pkg::OP_SUBI, 5, 'h17));
    emit(rr_word(cpu_pkg::OP_AND, 6, 5, 1));
    emit(rr_word(cpu_pkg::OP_OR, 7, 6, 2));
    emit(rr_word(cpu_pkg::OP_XOR, 0, 7, 4));
    emit(rr_word(cpu_pkg::OP_XOR, 2, 6, 5));
    emit(rr_word(cpu_pkg::OP_SUB, 3, 0, 7));
    emit(ri_word(cpu_pkg::OP_HALT, 0, 0));
    end_program(1, 'hB755, 'h1234, 'h8100, 'hA546, 'hA55A, 'h9300, 'h1200, 'h120F);

    // Stores and loads with a load-use on the next instruction
    emit(ri_word(cpu_pkg::OP_ADDI, 1, 'h20));
    emit(ri_word(cpu_pkg::OP_LDIH, 2, 'hBE));
    emit(ri_word(cpu_pkg::OP_ADDI, 2, 'hEF));
    emit(rm_word(cpu_pkg::OP_STORE, 2, 1, 3));
    emit(rm_word(cpu_pkg::OP_LOAD, 3, 1, 3));
    emit(rr_word(cpu_pkg::OP_ADD, 4, 3, 2));
    emit(rm_word(cpu_pkg::OP_LOAD, 5, 1, 7));
    emit(rm_word(cpu_pkg::OP_STORE, 5, 1, 8));
    emit(rm_word(cpu_pkg::OP_LOAD, 6, 1, 0));
    emit(rm_word(cpu_pkg::OP_LOAD, 7, 0, 'hF));
    emit(rm_word(cpu_pkg::OP_STORE, 4, 0, 5));
    emit(ri_word(cpu_pkg::OP_HALT, 0, 0));
    mem_word_check('h23, 'hBEEF);
    mem_word_check('h28, FROM_MEM + 'h27);
    mem_word_check('h05, 'h7DDE);
    mem_word_check('h27, FROM_MEM + 'h27);
    end_program(1, 0, 'h20, 'hBEEF, 'hBEEF, 'h7DDE,
                FROM_MEM + 'h27, FROM_MEM + 'h20, FROM_MEM + 'h0F);

    // Branches whose two following slots must die when taken
    emit(ri_word(cpu_pkg::OP_ADDI, 1, 5));
    emit(ri_word(cpu_pkg::OP_ADDI, 2, 5));
    emit(rr_word(cpu_pkg::OP_CMP, 0, 1, 2));
    emit(ri_word(cpu_pkg::OP_BZ, 0, 6));
    emit(ri_word(cpu_pkg::OP_ADDI, 3, 1));
    emit(ri_word(cpu_pkg::OP_ADDI, 4, 1));
    emit(ri_word(cpu_pkg::OP_BNZ, 0, 20));
    emit(rr_word(cpu_pkg::OP_SUB, 6, 1, 0));
    emit(ri_word(cpu_pkg::OP_BZ, 0, 20));
    emit(ri_word(cpu_pkg::OP_BNZ, 2, 7));
    emit(rm_word(cpu_pkg::OP_STORE, 1, 0, 1));
    emit(ri_word(cpu_pkg::OP_ADDI, 7, 9));
    emit(ri_word(cpu_pkg::OP_SUBI, 2, 5));
    emit(ri_word(cpu_pkg::OP_BZ, 2, 16));
    emit(ri_word(cpu_pkg::OP_ADDI, 3, 2));
    emit(ri_word(cpu_pkg::OP_ADDI, 4, 2));
    emit(ri_word(cpu_pkg::OP_JUMP, 0, 19));
    emit(ri_word(cpu_pkg::OP_ADDI, 5, 3));
    emit(ri_word(cpu_pkg::OP_ADDI, 6, 3));
    emit(ri_word(cpu_pkg::OP_ADDI, 7, 7));
    emit(ri_word(cpu_pkg::OP_HALT, 0, 0));
    mem_word_check('h01, FROM_MEM + 'h01);
    end_program(1, 0, 5, 0, 0, 0, 0, 5, 7);

    // Two runs with dead code past HALT
    emit(ri_word(cpu_pkg::OP_ADDI, 1, 1));
    emit(ri_word(cpu_pkg::OP_LDIH, 2, 1));
    emit(rm_word(cpu_pkg::OP_STORE, 1, 0, 9));
    emit(ri_word(cpu_pkg::OP_HALT, 0, 0));
    emit(ri_word(cpu_pkg::OP_ADDI, 3, 1));
    emit(rm_word(cpu_pkg::OP_STORE, 1, 0, 10));
    emit(ri_word(cpu_pkg::OP_ADDI, 1, 'h40));
    mem_word_check('h09, 2);
    mem_word_check('h0A, FROM_MEM + 'h0A);
    end_program(2, 0, 2, 'h200, 0, 0, 0, 0, 0);
endtask

//--- verif/tb_pipe_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_cpu;

    logic              CLK;
    logic              reset;
    logic              start;
    cpu_pkg::instr_t   i_datain;
    cpu_pkg::word_t    d_datain;
    cpu_pkg::reg_idx_t select_y;
    cpu_pkg::iaddr_t   i_addr;
    cpu_pkg::daddr_t   d_addr;
    cpu_pkg::word_t    d_dataout;
    logic              dw;
    cpu_pkg::word_t    y;
    logic              running;

    cpu_pkg::instr_t imem [256];
    cpu_pkg::word_t  dmem [256];
    cpu_pkg::word_t  dmem_init [256];
    integer          seed;
    int              cycles = 0;
    int              cycle_limit;

    `include "tb_programs.svh"

    pipe_cpu uut (
        .CLK       (CLK),
        .reset     (reset),
        .start     (start),
        .i_datain  (i_datain),
        .d_datain  (d_datain),
        .select_y  (select_y),
        .i_addr    (i_addr),
        .d_addr    (d_addr),
        .d_dataout (d_dataout),
        .dw        (dw),
        .y         (y),
        .running   (running)
    );

    always #5 CLK = ~CLK;

    ////////////////////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////////////////////
    assign i_datain = imem[i_addr];
    assign d_datain = dmem[d_addr];

    always @(posedge CLK) begin
        if (dw) begin
            dmem[d_addr] <= d_dataout;
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the programs did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $fatal(1, "simulation stopped");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic step_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic compare_word(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s read %h, expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // Literal value or the random word left at a data address
    function automatic cpu_pkg::word_t expected_word(int e);
        if (e >= FROM_MEM) begin
            return dmem_init[e - FROM_MEM];
        end
        return e[15:0];
    endfunction

    task automatic load_program(input int p);
        // Unused slots hold HALT tagged with their address
        for (int a = 0; a < 256; a++) begin
            imem[a] = {cpu_pkg::OP_HALT, 3'b000, 8'(a)};
        end
        for (int i = 0; i < code_len[p]; i++) begin
            imem[i] = code_tab[p][i];
        end
    endtask

    task automatic fill_data_memory();
        for (int a = 0; a < 256; a++) begin
            dmem[a]      = cpu_pkg::word_t'($random(seed));
            dmem_init[a] = dmem[a];
        end
    endtask

    task automatic apply_reset();
        reset = 1'b0;
        repeat (5) step_cycle();
        reset = 1'b1;
    endtask

    task automatic check_reset_state();
        compare_word("running after reset", running, 0);
        compare_word("dw after reset", dw, 0);
        for (int r = 0; r < 8; r++) begin
            select_y = cpu_pkg::reg_idx_t'(r);
            step_cycle();
            compare_word($sformatf("r%0d after reset", r), y, 0);
        end
    endtask

    task automatic run_to_halt();
        start = 1'b1;
        step_cycle();
        start = 1'b0;
        compare_word("running after start", running, 1);
        while (running) begin
            step_cycle();
        end
    endtask

    task automatic check_results(input int p);
        for (int r = 0; r < 8; r++) begin
            select_y = cpu_pkg::reg_idx_t'(r);
            step_cycle();
            compare_word($sformatf("program %0d r%0d", p, r), y, expected_word(reg_exp[p][r]));
        end
        for (int k = 0; k < mem_n[p]; k++) begin
            compare_word($sformatf("program %0d dmem[%0h]", p, mem_addr[p][k]),
                         dmem[mem_addr[p][k]], expected_word(mem_exp[p][k]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Program loop
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        CLK      = 1'b0;
        reset    = 1'b0;
        start    = 1'b0;
        select_y = '0;
        seed     = 66807;
        build_programs();
        for (int p = 0; p < NUM_PROGS; p++) begin
            load_program(p);
            fill_data_memory();
            apply_reset();
            check_reset_state();
            for (int n = 0; n < run_count[p]; n++) begin
                run_to_halt();
            end
            check_results(p);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/pipe_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_cpu (
    input  logic              CLK,
    input  logic              reset,
    input  logic              start,
    input  cpu_pkg::instr_t   i_datain,
    input  cpu_pkg::word_t    d_datain,
    input  cpu_pkg::reg_idx_t select_y,
    output cpu_pkg::iaddr_t   i_addr,
    output cpu_pkg::daddr_t   d_addr,
    output cpu_pkg::word_t    d_dataout,
    output logic              dw,
    output cpu_pkg::word_t    y,
    output logic              running
);

    logic              run;
    logic              halt_seen;
    logic              branch_taken;
    cpu_pkg::iaddr_t   branch_target;
    cpu_pkg::instr_t   fetch_ir;
    cpu_pkg::instr_t   ex_ir;
    cpu_pkg::instr_t   mem_ir;
    cpu_pkg::word_t    operand_a;
    cpu_pkg::word_t    operand_b;
    cpu_pkg::word_t    store_data;
    cpu_pkg::word_t    result;
    cpu_pkg::word_t    mem_store_data;
    cpu_pkg::reg_idx_t rf_idx_a;
    cpu_pkg::reg_idx_t rf_idx_b;
    cpu_pkg::reg_idx_t rf_idx_s;
    cpu_pkg::word_t    rf_a;
    cpu_pkg::word_t    rf_b;
    cpu_pkg::word_t    rf_s;
    logic              rf_wen;
    cpu_pkg::reg_idx_t rf_wr_idx;
    cpu_pkg::word_t    rf_wr_data;

    fwd_if fwd ();

    fetch_stage u_fetch (
        .CLK(CLK), .reset(reset), .start(start), .halt_seen(halt_seen),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .i_datain(i_datain), .i_addr(i_addr), .fetch_ir(fetch_ir), .run(run)
    );

    decode_stage u_decode (
        .CLK(CLK), .reset(reset), .run(run), .fetch_ir(fetch_ir),
        .branch_taken(branch_taken), .fwd(fwd.consumer),
        .rf_idx_a(rf_idx_a), .rf_idx_b(rf_idx_b), .rf_idx_s(rf_idx_s),
        .rf_a(rf_a), .rf_b(rf_b), .rf_s(rf_s), .ex_ir(ex_ir),
        .operand_a(operand_a), .operand_b(operand_b), .store_data(store_data)
    );

    execute_stage u_execute (
        .CLK(CLK), .reset(reset), .run(run), .ex_ir(ex_ir),
        .operand_a(operand_a), .operand_b(operand_b), .store_data(store_data),
        .fwd(fwd.producer_ex), .branch_taken(branch_taken),
        .branch_target(branch_target), .mem_ir(mem_ir), .result(result),
        .mem_store_data(mem_store_data), .dw(dw)
    );

    mem_wb_stage u_mem_wb (
        .CLK(CLK), .reset(reset), .run(run), .mem_ir(mem_ir), .result(result),
        .d_datain(d_datain), .fwd_mem(fwd.producer_mem), .fwd_wb(fwd.producer_wb),
        .rf_wen(rf_wen), .rf_wr_idx(rf_wr_idx), .rf_wr_data(rf_wr_data),
        .halt_seen(halt_seen)
    );

    reg_file u_reg_file (
        .CLK(CLK), .reset(reset),
        .rd_idx_a(rf_idx_a), .rd_idx_b(rf_idx_b), .rd_idx_s(rf_idx_s),
        .rd_a(rf_a), .rd_b(rf_b), .rd_s(rf_s),
        .wen(rf_wen), .wr_idx(rf_wr_idx), .wr_data(rf_wr_data),
        .dbg_idx(select_y), .dbg_data(y)
    );

    // Data memory sees the MEM stage registers directly
    assign d_addr    = result[7:0];
    assign d_dataout = mem_store_data;
    assign running   = run;

endmodule

`default_nettype wire

//--- hw/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic              CLK,
    input  logic              reset,
    input  logic              run,
    input  cpu_pkg::instr_t   mem_ir,
    input  cpu_pkg::word_t    result,
    input  cpu_pkg::word_t    d_datain,
    fwd_if.producer_mem       fwd_mem,
    fwd_if.producer_wb        fwd_wb,
    output logic              rf_wen,
    output cpu_pkg::reg_idx_t rf_wr_idx,
    output cpu_pkg::word_t    rf_wr_data,
    output logic              halt_seen
);

    cpu_pkg::opcode_e mem_op;
    cpu_pkg::opcode_e wb_op;
    cpu_pkg::instr_t  wb_ir;
    cpu_pkg::word_t   wb_data;
    cpu_pkg::word_t   mem_val;

    assign mem_op  = cpu_pkg::opc(mem_ir);
    assign wb_op   = cpu_pkg::opc(wb_ir);
    assign mem_val = (mem_op == cpu_pkg::OP_LOAD) ? d_datain : result;

    assign fwd_mem.mem_we  = cpu_pkg::writes_rd(mem_op);
    assign fwd_mem.mem_idx = mem_ir[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
    assign fwd_mem.mem_val = mem_val;

    always_ff @(posedge CLK) begin
        if (!reset) begin
            wb_ir <= cpu_pkg::NOP_IR;
        end else if (run) begin
            wb_ir <= mem_ir;
        end
    end

    always_ff @(posedge CLK) begin
        if (run) begin
            wb_data <= mem_val;
        end
    end

    assign fwd_wb.wb_we  = cpu_pkg::writes_rd(wb_op);
    assign fwd_wb.wb_idx = wb_ir[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
    assign fwd_wb.wb_val = wb_data;

    assign rf_wen     = run && cpu_pkg::writes_rd(wb_op);
    assign rf_wr_idx  = wb_ir[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
    assign rf_wr_data = wb_data;
    assign halt_seen  = (wb_op == cpu_pkg::OP_HALT);

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic            CLK,
    input  logic            reset,
    input  logic            run,
    input  cpu_pkg::instr_t ex_ir,
    input  cpu_pkg::word_t  operand_a,
    input  cpu_pkg::word_t  operand_b,
    input  cpu_pkg::word_t  store_data,
    fwd_if.producer_ex      fwd,
    output logic            branch_taken,
    output cpu_pkg::iaddr_t branch_target,
    output cpu_pkg::instr_t mem_ir,
    output cpu_pkg::word_t  result,
    output cpu_pkg::word_t  mem_store_data,
    output logic            dw
);

    cpu_pkg::opcode_e op;
    cpu_pkg::word_t   alu_out;
    logic             zf;

    assign op = cpu_pkg::opc(ex_ir);

    // Add covers addresses, LDIH and branch targets too
    always_comb begin
        case (op)
            cpu_pkg::OP_SUB, cpu_pkg::OP_SUBI,
            cpu_pkg::OP_CMP: alu_out = operand_a - operand_b;
            cpu_pkg::OP_AND: alu_out = operand_a & operand_b;
            cpu_pkg::OP_OR:  alu_out = operand_a | operand_b;
            cpu_pkg::OP_XOR: alu_out = operand_a ^ operand_b;
            default:         alu_out = operand_a + operand_b;
        endcase
    end

    always_comb begin
        branch_taken = (op == cpu_pkg::OP_JUMP)
                    || (op == cpu_pkg::OP_BZ && zf)
                    || (op == cpu_pkg::OP_BNZ && !zf);
    end
    assign branch_target = alu_out[7:0];

    // Load data is not ready here, MEM forwards it
    assign fwd.ex_we  = cpu_pkg::writes_rd(op) && op != cpu_pkg::OP_LOAD;
    assign fwd.ex_idx = ex_ir[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
    assign fwd.ex_val = alu_out;

    always_ff @(posedge CLK) begin
        if (!reset) begin
            zf     <= 1'b0;
            mem_ir <= cpu_pkg::NOP_IR;
            dw     <= 1'b0;
        end else if (run) begin
            case (op)
                cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI, cpu_pkg::OP_SUB,
                cpu_pkg::OP_SUBI, cpu_pkg::OP_CMP: zf <= (alu_out == '0);
                default: ;
            endcase
            mem_ir <= ex_ir;
            dw     <= (op == cpu_pkg::OP_STORE);
        end
    end

    always_ff @(posedge CLK) begin
        if (run) begin
            result         <= alu_out;
            mem_store_data <= store_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              CLK,
    input  logic              reset,
    input  logic              run,
    input  cpu_pkg::instr_t   fetch_ir,
    input  logic              branch_taken,
    fwd_if.consumer           fwd,
    output cpu_pkg::reg_idx_t rf_idx_a,
    output cpu_pkg::reg_idx_t rf_idx_b,
    output cpu_pkg::reg_idx_t rf_idx_s,
    input  cpu_pkg::word_t    rf_a,
    input  cpu_pkg::word_t    rf_b,
    input  cpu_pkg::word_t    rf_s,
    output cpu_pkg::instr_t   ex_ir,
    output cpu_pkg::word_t    operand_a,
    output cpu_pkg::word_t    operand_b,
    output cpu_pkg::word_t    store_data
);

    cpu_pkg::opcode_e          op;
    cpu_pkg::reg_idx_t         rd;
    logic [cpu_pkg::IMM8_W-1:0] imm8;
    logic [cpu_pkg::IMM4_W-1:0] imm4;
    logic                      a_is_zero;
    logic                      b_use_imm;
    cpu_pkg::word_t            b_imm;
    cpu_pkg::word_t            a_val;
    cpu_pkg::word_t            b_val;
    cpu_pkg::word_t            s_val;

    // Index 0 is EX, 1 is MEM, 2 is WB
    logic              cand_we  [3];
    cpu_pkg::reg_idx_t cand_idx [3];
    cpu_pkg::word_t    cand_val [3];

    assign op   = cpu_pkg::opc(fetch_ir);
    assign rd   = fetch_ir[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
    assign imm8 = fetch_ir[cpu_pkg::IMM8_W-1:0];
    assign imm4 = fetch_ir[cpu_pkg::IMM4_W-1:0];

    assign cand_we[0]  = fwd.ex_we;
    assign cand_idx[0] = fwd.ex_idx;
    assign cand_val[0] = fwd.ex_val;
    assign cand_we[1]  = fwd.mem_we;
    assign cand_idx[1] = fwd.mem_idx;
    assign cand_val[1] = fwd.mem_val;
    assign cand_we[2]  = fwd.wb_we;
    assign cand_idx[2] = fwd.wb_idx;
    assign cand_val[2] = fwd.wb_val;

    // Youngest producer wins, register file last
    function automatic cpu_pkg::word_t resolve(cpu_pkg::reg_idx_t r, cpu_pkg::word_t rf_val);
        cpu_pkg::word_t v;
        v = rf_val;
        for (int i = 2; i >= 0; i--) begin
            if (cand_we[i] && cand_idx[i] == r) begin
                v = cand_val[i];
            end
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Operand sources by opcode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rf_idx_a  = fetch_ir[cpu_pkg::RS1_MSB:cpu_pkg::RS1_LSB];
        rf_idx_b  = fetch_ir[cpu_pkg::RS2_MSB:cpu_pkg::RS2_LSB];
        rf_idx_s  = rd;
        a_is_zero = 1'b0;
        b_use_imm = 1'b0;
        b_imm     = '0;
        case (op)
            cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_LDIH,
            cpu_pkg::OP_BZ, cpu_pkg::OP_BNZ: rf_idx_a = rd;
            cpu_pkg::OP_JUMP:                a_is_zero = 1'b1;
            default: ;
        endcase
        case (op)
            cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_BZ,
            cpu_pkg::OP_BNZ, cpu_pkg::OP_JUMP: begin
                b_use_imm = 1'b1;
                b_imm     = cpu_pkg::word_t'(imm8);
            end
            cpu_pkg::OP_LDIH: begin
                b_use_imm = 1'b1;
                b_imm     = {imm8, {cpu_pkg::IMM8_W{1'b0}}};
            end
            cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE: begin
                b_use_imm = 1'b1;
                b_imm     = cpu_pkg::word_t'(imm4);
            end
            default: ;
        endcase
    end

    always_comb begin
        a_val = a_is_zero ? '0 : resolve(rf_idx_a, rf_a);
        b_val = b_use_imm ? b_imm : resolve(rf_idx_b, rf_b);
        s_val = resolve(rf_idx_s, rf_s);
    end

    always_ff @(posedge CLK) begin
        if (!reset) begin
            ex_ir <= cpu_pkg::NOP_IR;
        end else if (run) begin
            ex_ir <= branch_taken ? cpu_pkg::NOP_IR : fetch_ir;
        end
    end

    always_ff @(posedge CLK) begin
        if (run) begin
            operand_a  <= a_val;
            operand_b  <= b_val;
            store_data <= s_val;
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic            CLK,
    input  logic            reset,
    input  logic            start,
    input  logic            halt_seen,
    input  logic            branch_taken,
    input  cpu_pkg::iaddr_t branch_target,
    input  cpu_pkg::instr_t i_datain,
    output cpu_pkg::iaddr_t i_addr,
    output cpu_pkg::instr_t fetch_ir,
    output logic            run
);

    cpu_pkg::run_state_e state;
    cpu_pkg::iaddr_t     pc;
    cpu_pkg::opcode_e    dec_op;
    // Set once HALT leaves fetch, keeps younger slots empty
    logic                halted;

    assign dec_op = cpu_pkg::opc(fetch_ir);
    assign i_addr = pc;
    assign run    = (state == cpu_pkg::run);

    ////////////////////////////////////////////////////////////////////////////
    // Run control and pc
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (!reset) begin
            state    <= cpu_pkg::idle;
            pc       <= '0;
            fetch_ir <= cpu_pkg::NOP_IR;
            halted   <= 1'b0;
        end else if (state == cpu_pkg::idle) begin
            if (start) begin
                state  <= cpu_pkg::run;
                pc     <= '0;
                halted <= 1'b0;
            end
        end else begin
            if (halt_seen) begin
                state <= cpu_pkg::idle;
            end
            if (branch_taken) begin
                pc       <= branch_target;
                fetch_ir <= cpu_pkg::NOP_IR;
            end else if (halted || dec_op == cpu_pkg::OP_HALT) begin
                fetch_ir <= cpu_pkg::NOP_IR;
                halted   <= 1'b1;
            end else if (dec_op == cpu_pkg::OP_LOAD) begin
                // Hold pc, one bubble behind the load
                fetch_ir <= cpu_pkg::NOP_IR;
            end else begin
                fetch_ir <= i_datain;
                pc       <= pc + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              CLK,
    input  logic              reset,
    input  cpu_pkg::reg_idx_t rd_idx_a,
    input  cpu_pkg::reg_idx_t rd_idx_b,
    input  cpu_pkg::reg_idx_t rd_idx_s,
    output cpu_pkg::word_t    rd_a,
    output cpu_pkg::word_t    rd_b,
    output cpu_pkg::word_t    rd_s,
    input  logic              wen,
    input  cpu_pkg::reg_idx_t wr_idx,
    input  cpu_pkg::word_t    wr_data,
    input  cpu_pkg::reg_idx_t dbg_idx,
    output cpu_pkg::word_t    dbg_data
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge CLK) begin
        if (!reset) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Same-cycle writes reach decode through the WB forward path
    assign rd_a     = regs[rd_idx_a];
    assign rd_b     = regs[rd_idx_b];
    assign rd_s     = regs[rd_idx_s];
    assign dbg_data = regs[dbg_idx];

endmodule

`default_nettype wire

//--- hw/fwd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fwd_if;

    // EX candidate, live ALU output
    logic              ex_we;
    cpu_pkg::reg_idx_t ex_idx;
    cpu_pkg::word_t    ex_val;

    // MEM candidate, load data already selected
    logic              mem_we;
    cpu_pkg::reg_idx_t mem_idx;
    cpu_pkg::word_t    mem_val;

    // WB candidate, value about to be written
    logic              wb_we;
    cpu_pkg::reg_idx_t wb_idx;
    cpu_pkg::word_t    wb_val;

    modport producer_ex  (output ex_we, ex_idx, ex_val);
    modport producer_mem (output mem_we, mem_idx, mem_val);
    modport producer_wb  (output wb_we, wb_idx, wb_val);
    modport consumer (
        input ex_we, ex_idx, ex_val,
        input mem_we, mem_idx, mem_val,
        input wb_we, wb_idx, wb_val
    );

endinterface

`default_nettype wire

//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int NUM_REGS = 8;

    // Instruction field positions
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 11;
    localparam int RD_MSB  = 10;
    localparam int RD_LSB  = 8;
    localparam int RS1_MSB = 6;
    localparam int RS1_LSB = 4;
    localparam int RS2_MSB = 2;
    localparam int RS2_LSB = 0;
    localparam int IMM8_W  = 8;
    localparam int IMM4_W  = 4;

    typedef logic [15:0] word_t;
    typedef logic [15:0] instr_t;
    typedef logic [7:0]  iaddr_t;
    typedef logic [7:0]  daddr_t;
    typedef logic [2:0]  reg_idx_t;

    typedef enum logic [4:0] {
        OP_NOP   = 5'b00000,
        OP_HALT  = 5'b00001,
        OP_LOAD  = 5'b00010,
        OP_STORE = 5'b00011,
        OP_LDIH  = 5'b10000,
        OP_ADD   = 5'b01000,
        OP_ADDI  = 5'b01001,
        OP_SUB   = 5'b01010,
        OP_SUBI  = 5'b01011,
        OP_CMP   = 5'b01100,
        OP_AND   = 5'b01101,
        OP_OR    = 5'b01110,
        OP_XOR   = 5'b01111,
        OP_JUMP  = 5'b11000,
        OP_BZ    = 5'b11010,
        OP_BNZ   = 5'b11011
    } opcode_e;

    typedef enum logic {
        idle = 1'b0,
        run  = 1'b1
    } run_state_e;

    // Bubble inserted on flush and load stall
    localparam instr_t NOP_IR = {OP_NOP, 11'b0};

    function automatic opcode_e opc(instr_t ir);
        return opcode_e'(ir[OPC_MSB:OPC_LSB]);
    endfunction

    // Instructions that write rd in WB
    function automatic logic writes_rd(opcode_e op);
        case (op)
            OP_LOAD, OP_LDIH, OP_ADD, OP_ADDI, OP_SUB, OP_SUBI,
            OP_AND, OP_OR, OP_XOR: return 1'b1;
            default:               return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire
